// ==== sim/xbar_golden.txt ====
# op addr wdata resp rdata (all hex, op W or R)
# resp 0 is OKAY and 3 is DECERR, rdata is only checked on reads
R 20000000 00000000 0 00000000
R 00000000 00000000 0 00000000
W 20000010 a5a50001 0 00000000
R 20000010 00000000 0 a5a50001
R 00000020 00000000 0 00000000
W 00000020 5a5a0002 0 00000000
R 00000020 00000000 0 5a5a0002
R 2fffffff 00000000 0 a5a50001
W 10000000 deadbeef 3 00000000
R 10000004 00000000 3 00000000
W f0000000 cafef00d 3 00000000
R fffffffc 00000000 3 00000000
R 20000000 00000000 0 a5a50001
R 00000000 00000000 0 5a5a0002
W 2abcdef0 12345678 0 00000000
W 2abcdef4 87654321 0 00000000
R 20000000 00000000 0 87654321
W 0ffffffc 0badc0de 0 00000000
R 0ffffffc 00000000 0 0badc0de
W 30000000 11111111 3 00000000
R 30000000 00000000 3 00000000
W 00000004 ffffffff 0 00000000
R 2ffffff0 00000000 0 87654321
R 00000008 00000000 0 ffffffff
W 20000000 00000000 0 00000000
R 20000000 00000000 0 00000000
W e0000000 13579bdf 3 00000000
R 1fffffff 00000000 3 00000000
R 0ffffff8 00000000 0 ffffffff
W 20000008 fedcba98 0 00000000
R 2000000c 00000000 0 fedcba98

// ==== list.f ====
design/xbar_pkg.sv
design/xbar_addr_decoder.sv
design/xbar_req_buffer.sv
design/xbar_slave_sink.sv
design/xbar_system.sv
sim/xbar_system_tb.sv

// ==== Makefile ====
TOP = xbar_system_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf obj_dir

// ==== sim/xbar_system_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module xbar_system_tb
    import xbar_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int SAMPLE_DELAY    = 25;
    localparam int CYCLES_PER_TEST = 60;
    localparam logic [31:0] RNG_SEED = 32'hf9640973;

    logic        clock;
    logic        rst;
    logic        awvalid;
    logic [31:0] awaddr;
    logic        awready;
    logic        wvalid;
    logic [31:0] wdata;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        bready;
    logic        arvalid;
    logic [31:0] araddr;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rready;
    logic [31:0] write_addr_a;
    logic [31:0] write_data_a;
    logic [31:0] read_addr_a;
    logic [31:0] write_addr_b;
    logic [31:0] write_data_b;
    logic [31:0] read_addr_b;

    // Golden transactions with one entry per data line of the file
    logic [7:0]  ops [$];
    logic [31:0] addrs [$];
    logic [31:0] wdatas [$];
    logic [1:0]  exp_resps [$];
    logic [31:0] exp_rdatas [$];
    int          num_tests = 0;

    // Expected slave outputs where index 0 is slave A and index 1 is slave B
    logic [31:0] model_waddr [0:1];
    logic [31:0] model_wdata [0:1];
    logic [31:0] model_raddr [0:1];

    xbar_system uut (
        .clock(clock), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .write_addr_a(write_addr_a), .write_data_a(write_data_a), .read_addr_a(read_addr_a),
        .write_addr_b(write_addr_b), .write_data_b(write_data_b), .read_addr_b(read_addr_b)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Region in the top nibble picks the slave and any other region is unmapped
    function automatic int slave_of(input logic [31:0] addr);
        if (addr[31:28] == REGION_A) return 0;
        if (addr[31:28] == REGION_B) return 1;
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_slaves(input string tag);
        check_value({tag, " write_addr_a"}, model_waddr[0], write_addr_a);
        check_value({tag, " write_data_a"}, model_wdata[0], write_data_a);
        check_value({tag, " read_addr_a"}, model_raddr[0], read_addr_a);
        check_value({tag, " write_addr_b"}, model_waddr[1], write_addr_b);
        check_value({tag, " write_data_b"}, model_wdata[1], write_data_b);
        check_value({tag, " read_addr_b"}, model_raddr[1], read_addr_b);
    endtask

    // Holds the request valid until the address handshake completes
    task automatic send_request(input logic is_write, input logic [31:0] addr,
                                input logic [31:0] data);
        logic accepted;
        @(negedge clock);
        if (is_write) begin
            awaddr = addr;
            wdata = data;
            awvalid = 1'b1;
            wvalid = 1'b1;
        end else begin
            araddr = addr;
            arvalid = 1'b1;
        end
        accepted = 1'b0;
        while (!accepted) begin
            #(SAMPLE_DELAY);
            accepted = is_write ? (awready && wready) : arready;
            @(negedge clock);
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
    endtask

    task automatic take_response(input logic is_write, input string tag,
                                 output logic [1:0] resp, output logic [31:0] data);
        logic taken;
        taken = 1'b0;
        resp = 2'd0;
        data = 32'd0;
        while (!taken) begin
            #(SAMPLE_DELAY);
            if (is_write) begin
                taken = bvalid && bready;
                resp = bresp;
            end else begin
                taken = rvalid && rready;
                resp = rresp;
                data = rdata;
            end
            @(negedge clock);
        end
        // The response went out on the last edge and must not appear again
        #(SAMPLE_DELAY);
        check_value({tag, " valid after handshake"}, 32'd0, 32'(is_write ? bvalid : rvalid));
    endtask

    // About one cycle in four holds each ready low
    initial begin
        logic [31:0] rng;
        rng = RNG_SEED;
        bready = 1'b0;
        rready = 1'b0;
        forever begin
            @(negedge clock);
            rng = xorshift32(rng);
            bready = (rng[1:0] != 2'b00);
            rng = xorshift32(rng);
            rready = (rng[1:0] != 2'b00);
        end
    end

    initial begin
        wait (num_tests > 0);
        #(num_tests * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the %0d golden transactions did not finish in time", num_tests);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          fd;
        int          s;
        string       line;
        string       tag;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] rd;
        logic        is_write;
        logic [1:0]  got_resp;
        logic [31:0] got_data;

        rst = 1'b1;
        awvalid = 1'b0;
        awaddr = 32'd0;
        wvalid = 1'b0;
        wdata = 32'd0;
        arvalid = 1'b0;
        araddr = 32'd0;
        for (int k = 0; k < 2; k++) begin
            model_waddr[k] = 32'd0;
            model_wdata[k] = 32'd0;
            model_raddr[k] = 32'd0;
        end

        fd = $fopen("sim/xbar_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file sim/xbar_golden.txt");
            $display("Test FAILED");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;
            if ($sscanf(line, "%s %h %h %h %h", op, addr, data, resp, rd) == 5) begin
                if (op != "W" && op != "R") begin
                    $display("Golden file has an unknown operation in line: %s", line);
                    $display("Test FAILED");
                    $fatal(1, "bad golden line");
                end
                ops.push_back(op);
                addrs.push_back(addr);
                wdatas.push_back(data);
                exp_resps.push_back(resp);
                exp_rdatas.push_back(rd);
            end
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            $display("Golden file holds no transactions");
            $display("Test FAILED");
            $fatal(1, "empty stimulus");
        end
        num_tests = ops.size();

        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        #(SAMPLE_DELAY);
        check_slaves("after reset");

        for (int i = 0; i < num_tests; i++) begin
            is_write = (ops[i] == "W");
            if (is_write) begin
                tag = $sformatf("test %0d write %h", i + 1, addrs[i]);
            end else begin
                tag = $sformatf("test %0d read %h", i + 1, addrs[i]);
            end
            send_request(is_write, addrs[i], wdatas[i]);
            take_response(is_write, tag, got_resp, got_data);
            check_value({tag, " resp"}, 32'(exp_resps[i]), 32'(got_resp));
            if (!is_write) begin
                check_value({tag, " rdata"}, exp_rdatas[i], got_data);
            end
            s = slave_of(addrs[i]);
            if (s >= 0 && is_write) begin
                model_waddr[s] = addrs[i];
                model_wdata[s] = wdatas[i];
            end else if (s >= 0) begin
                model_raddr[s] = addrs[i];
            end
            check_slaves(tag);
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/xbar_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module xbar_system
    import xbar_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  rst,
    input  wire logic                  awvalid,
    input  wire logic [ADDR_WIDTH-1:0] awaddr,
    output logic                       awready,
    input  wire logic                  wvalid,
    input  wire logic [DATA_WIDTH-1:0] wdata,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  wire logic                  bready,
    input  wire logic                  arvalid,
    input  wire logic [ADDR_WIDTH-1:0] araddr,
    output logic                       arready,
    output logic                       rvalid,
    output logic [DATA_WIDTH-1:0]      rdata,
    output logic [1:0]                 rresp,
    input  wire logic                  rready,
    output logic [ADDR_WIDTH-1:0]      write_addr_a,
    output logic [DATA_WIDTH-1:0]      write_data_a,
    output logic [ADDR_WIDTH-1:0]      read_addr_a,
    output logic [ADDR_WIDTH-1:0]      write_addr_b,
    output logic [DATA_WIDTH-1:0]      write_data_b,
    output logic [ADDR_WIDTH-1:0]      read_addr_b
);

    // Decoder side of the request buffers
    logic                    wr_req_valid_a;
    logic [WR_REQ_WIDTH-1:0] wr_req_data_a;
    logic                    wr_req_ready_a;
    logic                    wr_req_valid_b;
    logic [WR_REQ_WIDTH-1:0] wr_req_data_b;
    logic                    wr_req_ready_b;
    logic                    rd_req_valid_a;
    logic [RD_REQ_WIDTH-1:0] rd_req_data_a;
    logic                    rd_req_ready_a;
    logic                    rd_req_valid_b;
    logic [RD_REQ_WIDTH-1:0] rd_req_data_b;
    logic                    rd_req_ready_b;

    // Sink side of the request buffers
    logic                    wr_valid_a;
    logic [WR_REQ_WIDTH-1:0] wr_data_a;
    logic                    wr_ready_a;
    logic                    wr_valid_b;
    logic [WR_REQ_WIDTH-1:0] wr_data_b;
    logic                    wr_ready_b;
    logic                    rd_valid_a;
    logic [RD_REQ_WIDTH-1:0] rd_addr_a;
    logic                    rd_ready_a;
    logic                    rd_valid_b;
    logic [RD_REQ_WIDTH-1:0] rd_addr_b;
    logic                    rd_ready_b;

    logic                    wr_done_a;
    logic                    wr_done_b;
    logic                    rd_done_a;
    logic                    rd_done_b;
    logic [DATA_WIDTH-1:0]   rd_data_a;
    logic [DATA_WIDTH-1:0]   rd_data_b;

    xbar_addr_decoder decoder (
        .clock(clock), .rst(rst),
        .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wready(wready),
        .bvalid(bvalid), .bresp(bresp), .bready(bready),
        .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
        .wr_req_valid_a(wr_req_valid_a), .wr_req_data_a(wr_req_data_a),
        .wr_req_ready_a(wr_req_ready_a),
        .wr_req_valid_b(wr_req_valid_b), .wr_req_data_b(wr_req_data_b),
        .wr_req_ready_b(wr_req_ready_b),
        .rd_req_valid_a(rd_req_valid_a), .rd_req_data_a(rd_req_data_a),
        .rd_req_ready_a(rd_req_ready_a),
        .rd_req_valid_b(rd_req_valid_b), .rd_req_data_b(rd_req_data_b),
        .rd_req_ready_b(rd_req_ready_b),
        .wr_done_a(wr_done_a), .wr_done_b(wr_done_b),
        .rd_done_a(rd_done_a), .rd_done_b(rd_done_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

    xbar_req_buffer #(.WIDTH(WR_REQ_WIDTH)) wr_buf_a (
        .clock(clock), .rst(rst),
        .in_valid(wr_req_valid_a), .in_data(wr_req_data_a), .in_ready(wr_req_ready_a),
        .out_valid(wr_valid_a), .out_data(wr_data_a), .out_ready(wr_ready_a)
    );

    xbar_req_buffer #(.WIDTH(RD_REQ_WIDTH)) rd_buf_a (
        .clock(clock), .rst(rst),
        .in_valid(rd_req_valid_a), .in_data(rd_req_data_a), .in_ready(rd_req_ready_a),
        .out_valid(rd_valid_a), .out_data(rd_addr_a), .out_ready(rd_ready_a)
    );

    xbar_req_buffer #(.WIDTH(WR_REQ_WIDTH)) wr_buf_b (
        .clock(clock), .rst(rst),
        .in_valid(wr_req_valid_b), .in_data(wr_req_data_b), .in_ready(wr_req_ready_b),
        .out_valid(wr_valid_b), .out_data(wr_data_b), .out_ready(wr_ready_b)
    );

    xbar_req_buffer #(.WIDTH(RD_REQ_WIDTH)) rd_buf_b (
        .clock(clock), .rst(rst),
        .in_valid(rd_req_valid_b), .in_data(rd_req_data_b), .in_ready(rd_req_ready_b),
        .out_valid(rd_valid_b), .out_data(rd_addr_b), .out_ready(rd_ready_b)
    );

    xbar_slave_sink slave_a (
        .clock(clock), .rst(rst),
        .wr_valid(wr_valid_a), .wr_data(wr_data_a), .wr_ready(wr_ready_a),
        .rd_valid(rd_valid_a), .rd_data_in(rd_addr_a), .rd_ready(rd_ready_a),
        .wr_done(wr_done_a), .rd_done(rd_done_a), .rd_data(rd_data_a),
        .write_addr(write_addr_a), .write_data(write_data_a), .read_addr(read_addr_a)
    );

    xbar_slave_sink slave_b (
        .clock(clock), .rst(rst),
        .wr_valid(wr_valid_b), .wr_data(wr_data_b), .wr_ready(wr_ready_b),
        .rd_valid(rd_valid_b), .rd_data_in(rd_addr_b), .rd_ready(rd_ready_b),
        .wr_done(wr_done_b), .rd_done(rd_done_b), .rd_data(rd_data_b),
        .write_addr(write_addr_b), .write_data(write_data_b), .read_addr(read_addr_b)
    );

endmodule

`default_nettype wire

// ==== design/xbar_slave_sink.sv ====
`timescale 1ns/10ps
`default_nettype none

module xbar_slave_sink
    import xbar_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    rst,
    input  wire logic                    wr_valid,
    input  wire logic [WR_REQ_WIDTH-1:0] wr_data,
    output logic                         wr_ready,
    input  wire logic                    rd_valid,
    input  wire logic [RD_REQ_WIDTH-1:0] rd_data_in,
    output logic                         rd_ready,
    output logic                         wr_done,
    output logic                         rd_done,
    output logic [DATA_WIDTH-1:0]        rd_data,
    output logic [ADDR_WIDTH-1:0]        write_addr,
    output logic [DATA_WIDTH-1:0]        write_data,
    output logic [ADDR_WIDTH-1:0]        read_addr
);

    logic accept_en;
    logic wr_fire;
    logic rd_fire;

    // Set on the first edge out of reset and held from then on
    always_ff @(posedge clock) begin
        if (rst) begin
            accept_en <= 1'b0;
        end else begin
            accept_en <= 1'b1;
        end
    end

    // A write in the same cycle wins and the read waits one more cycle
    assign wr_ready = accept_en;
    assign rd_ready = accept_en && !wr_valid;

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_done    <= 1'b0;
            rd_done    <= 1'b0;
            write_addr <= '0;
            write_data <= '0;
            read_addr  <= '0;
            rd_data    <= '0;
        end else begin
            wr_done <= wr_fire;
            rd_done <= rd_fire;
            if (wr_fire) begin
                write_addr <= wr_data[WR_REQ_WIDTH-1:DATA_WIDTH];
                write_data <= wr_data[DATA_WIDTH-1:0];
            end
            if (rd_fire) begin
                read_addr <= rd_data_in;
                // Reads return whatever this slave last stored
                rd_data   <= write_data;
            end
        end
    end

    // Each request is answered by exactly one single-cycle pulse
    assert property (@(posedge clock) disable iff (rst) wr_done |=> !wr_done);
    assert property (@(posedge clock) disable iff (rst) rd_done |=> !rd_done);

endmodule

`default_nettype wire

// ==== design/xbar_req_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module xbar_req_buffer #(
    parameter int WIDTH = 32
) (
    input  wire logic             clock,
    input  wire logic             rst,
    input  wire logic             in_valid,
    input  wire logic [WIDTH-1:0] in_data,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic [WIDTH-1:0]      out_data,
    input  wire logic             out_ready
);

    logic [WIDTH-1:0] mem [0:1];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic             push;
    logic             pop;

    // Ready only drops once both slots hold a request
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // The incoming request lands in the slot at the write pointer
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // The head entry must not move while the sink is stalling it
    assert property (@(posedge clock) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// ==== design/xbar_addr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module xbar_addr_decoder
    import xbar_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    rst,
    input  wire logic                    awvalid,
    input  wire logic [ADDR_WIDTH-1:0]   awaddr,
    output logic                         awready,
    input  wire logic                    wvalid,
    input  wire logic [DATA_WIDTH-1:0]   wdata,
    output logic                         wready,
    output logic                         bvalid,
    output logic [1:0]                   bresp,
    input  wire logic                    bready,
    input  wire logic                    arvalid,
    input  wire logic [ADDR_WIDTH-1:0]   araddr,
    output logic                         arready,
    output logic                         rvalid,
    output logic [DATA_WIDTH-1:0]        rdata,
    output logic [1:0]                   rresp,
    input  wire logic                    rready,
    output logic                         wr_req_valid_a,
    output logic [WR_REQ_WIDTH-1:0]      wr_req_data_a,
    input  wire logic                    wr_req_ready_a,
    output logic                         wr_req_valid_b,
    output logic [WR_REQ_WIDTH-1:0]      wr_req_data_b,
    input  wire logic                    wr_req_ready_b,
    output logic                         rd_req_valid_a,
    output logic [RD_REQ_WIDTH-1:0]      rd_req_data_a,
    input  wire logic                    rd_req_ready_a,
    output logic                         rd_req_valid_b,
    output logic [RD_REQ_WIDTH-1:0]      rd_req_data_b,
    input  wire logic                    rd_req_ready_b,
    input  wire logic                    wr_done_a,
    input  wire logic                    wr_done_b,
    input  wire logic                    rd_done_a,
    input  wire logic                    rd_done_b,
    input  wire logic [DATA_WIDTH-1:0]   rd_data_a,
    input  wire logic [DATA_WIDTH-1:0]   rd_data_b
);

    logic [1:0]            wr_state;
    logic [1:0]            rd_state;
    xbar_addr_t            aw_word;
    xbar_addr_t            ar_word;
    xbar_addr_t            wr_req_word;
    xbar_addr_t            rd_req_word;
    logic                  aw_fire;
    logic                  ar_fire;
    logic                  aw_hit_a;
    logic                  aw_hit_b;
    logic                  ar_hit_a;
    logic                  ar_hit_b;
    logic                  wr_sel_b;
    logic                  rd_sel_b;
    logic [WR_REQ_WIDTH-1:0] wr_payload;
    logic [RD_REQ_WIDTH-1:0] rd_payload;

    assign aw_word = awaddr;
    assign ar_word = araddr;
    assign aw_hit_a = (aw_word.field.region == REGION_A);
    assign aw_hit_b = (aw_word.field.region == REGION_B);
    assign ar_hit_a = (ar_word.field.region == REGION_A);
    assign ar_hit_b = (ar_word.field.region == REGION_B);

    // Address and data channels of a write are taken on the same edge
    assign aw_fire = awvalid && wvalid && (wr_state == ST_IDLE);
    assign awready = aw_fire;
    assign wready  = aw_fire;
    assign ar_fire = arvalid && (rd_state == ST_IDLE);
    assign arready = ar_fire;

    assign bvalid = (wr_state == ST_RESP);
    assign rvalid = (rd_state == ST_RESP);

    // Both slaves see the same payload and only the valid selects one
    assign wr_req_data_a  = wr_payload;
    assign wr_req_data_b  = wr_payload;
    assign rd_req_data_a  = rd_payload;
    assign rd_req_data_b  = rd_payload;
    assign wr_req_valid_a = (wr_state == ST_ISSUE) && !wr_sel_b;
    assign wr_req_valid_b = (wr_state == ST_ISSUE) && wr_sel_b;
    assign rd_req_valid_a = (rd_state == ST_ISSUE) && !rd_sel_b;
    assign rd_req_valid_b = (rd_state == ST_ISSUE) && rd_sel_b;

    assign wr_req_word = wr_payload[WR_REQ_WIDTH-1:DATA_WIDTH];
    assign rd_req_word = rd_payload;

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_state <= ST_IDLE;
            wr_sel_b <= 1'b0;
        end else begin
            case (wr_state)
                ST_IDLE: begin
                    if (aw_fire) begin
                        wr_sel_b <= aw_hit_b;
                        // Unmapped regions skip the slaves entirely
                        wr_state <= (aw_hit_a || aw_hit_b) ? ST_ISSUE : ST_RESP;
                    end
                end
                ST_ISSUE: begin
                    if (wr_sel_b ? wr_req_ready_b : wr_req_ready_a) wr_state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (wr_sel_b ? wr_done_b : wr_done_a) wr_state <= ST_RESP;
                end
                default: begin
                    if (bready) wr_state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            rd_state <= ST_IDLE;
            rd_sel_b <= 1'b0;
        end else begin
            case (rd_state)
                ST_IDLE: begin
                    if (ar_fire) begin
                        rd_sel_b <= ar_hit_b;
                        rd_state <= (ar_hit_a || ar_hit_b) ? ST_ISSUE : ST_RESP;
                    end
                end
                ST_ISSUE: begin
                    if (rd_sel_b ? rd_req_ready_b : rd_req_ready_a) rd_state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (rd_sel_b ? rd_done_b : rd_done_a) rd_state <= ST_RESP;
                end
                default: begin
                    if (rready) rd_state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire) begin
            wr_payload <= {awaddr, wdata};
            bresp      <= (aw_hit_a || aw_hit_b) ? RESP_OKAY : RESP_DECERR;
        end
        if (ar_fire) begin
            rd_payload <= araddr;
            rresp      <= (ar_hit_a || ar_hit_b) ? RESP_OKAY : RESP_DECERR;
            rdata      <= '0;
        end else if ((rd_state == ST_WAIT) && (rd_sel_b ? rd_done_b : rd_done_a)) begin
            rdata <= rd_sel_b ? rd_data_b : rd_data_a;
        end
    end

    // A response stays on the bus with its payload until the master takes it
    assert property (@(posedge clock) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));
    assert property (@(posedge clock) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

    // A request reaches only the slave named by its region and never both slaves at once
    assert property (@(posedge clock) disable iff (rst)
        wr_req_valid_a |-> (wr_req_word.field.region == REGION_A));
    assert property (@(posedge clock) disable iff (rst)
        wr_req_valid_b |-> (wr_req_word.field.region == REGION_B));
    assert property (@(posedge clock) disable iff (rst)
        rd_req_valid_a |-> (rd_req_word.field.region == REGION_A));
    assert property (@(posedge clock) disable iff (rst)
        rd_req_valid_b |-> (rd_req_word.field.region == REGION_B));

endmodule

`default_nettype wire

// ==== design/xbar_pkg.sv ====
`default_nettype none

package xbar_pkg;

    // Bus widths of the master side
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    // A write request carries address and data, a read request only the address
    localparam int WR_REQ_WIDTH = ADDR_WIDTH + DATA_WIDTH;
    localparam int RD_REQ_WIDTH = ADDR_WIDTH;

    // Top address nibble that selects each slave
    localparam logic [3:0] REGION_A = 4'h2;
    localparam logic [3:0] REGION_B = 4'h0;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // States shared by the write and read FSMs of the decoder
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_ISSUE = 2'd1;
    localparam logic [1:0] ST_WAIT  = 2'd2;
    localparam logic [1:0] ST_RESP  = 2'd3;

    // One address word seen either as a whole or split into region and offset
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        struct packed {
            logic [3:0]  region;
            logic [27:0] offset;
        } field;
    } xbar_addr_t;

endpackage

`default_nettype wire
